// File: flist.f
rtl/cmd_seq_pkg.sv
rtl/cmd_seq_regs.sv
rtl/cmd_seq_mem.sv
rtl/cmd_seq_ctrl.sv
rtl/cmd_seq_encoder.sv
rtl/cmd_seq_top.sv
testbench/tb_cmd_seq.sv

// File: rtl/cmd_seq_ctrl.sv
// command sequencer control
// FSM with bit and repeat counters, memory addressing, start sources,
// start_req/start_ack handshake and the start pulse

`timescale 1ns/1ps

module cmd_seq_ctrl #(
    parameter int CMD_MEM_SIZE = 2048
) (
    input  logic                            CMD_CLK_IN,
    input  logic                            RST_CMD_CLK,
    input  logic                            bus_start,
    input  logic                            ext_start_flag,
    input  logic                            ext_start_en,
    input  logic                            start_req,
    output logic                            start_ack,
    input  logic [15:0]                     cmd_size,
    input  logic [31:0]                     repeat_count,
    input  logic [15:0]                     start_repeat,
    input  logic [15:0]                     stop_repeat,
    input  logic                            dis_start_pulse,
    output logic                            ready,
    output logic                            start_pulse,
    output logic [$clog2(CMD_MEM_SIZE)-1:0] mem_rd_addr,
    input  logic [7:0]                      mem_rd_data,
    output logic [7:0]                      word,
    output logic                            word_load,
    output logic [2:0]                      bit_sel,
    output logic                            bit_valid
);

    localparam int MEM_AW = $clog2(CMD_MEM_SIZE);

    cmd_seq_pkg::seq_state_e state, next_state;

    logic [15:0] cnt;        // pattern bit being fetched
    logic [31:0] rep_cnt;    // pass number from 1
    logic        jumped;     // cnt was just reloaded by a wrap
    logic [15:0] mid_end;
    logic [15:0] last_bit;
    logic [15:0] byte_idx;
    logic        take_req;
    logic        take;
    logic        wrap;
    logic        last;
    logic        pulse_s1;

    assign take_req = start_req && !start_ack;  // one start per handshake
    assign take     = (state == cmd_seq_pkg::IDLE)
                      && (bus_start || (ext_start_flag && ext_start_en) || take_req);

    assign mid_end  = cmd_size - stop_repeat - 16'd1;
    assign last_bit = cmd_size - 16'd1;
    assign wrap     = (cnt == mid_end) && (rep_cnt < repeat_count);
    assign last     = (cnt == last_bit) && !wrap;

    always_comb begin
        next_state = state;
        case (state)
            cmd_seq_pkg::IDLE:     if (take) next_state = cmd_seq_pkg::SEND;
            cmd_seq_pkg::SEND:     if (last) next_state = cmd_seq_pkg::HOLD_ACK;
            cmd_seq_pkg::HOLD_ACK: if (!bit_valid && !start_ack) next_state = cmd_seq_pkg::IDLE;
            default:               next_state = cmd_seq_pkg::IDLE;
        endcase
    end

    always_ff @(posedge CMD_CLK_IN) begin
        if (RST_CMD_CLK) begin
            state   <= cmd_seq_pkg::IDLE;
            cnt     <= 16'd0;
            rep_cnt <= 32'd1;
            jumped  <= 1'b0;
        end else begin
            state  <= next_state;
            jumped <= 1'b0;
            if (take) begin
                cnt     <= 16'd0;
                rep_cnt <= 32'd1;
            end else if (state == cmd_seq_pkg::SEND) begin
                if (wrap) begin
                    cnt     <= start_repeat;  // back to the start-repeat point
                    rep_cnt <= rep_cnt + 32'd1;
                    jumped  <= 1'b1;
                end else if (!last) begin
                    cnt <= cnt + 16'd1;
                end
            end
        end
    end

    // byte address one stage ahead of the encoder
    assign byte_idx    = {3'd0, cnt[15:3]};
    assign mem_rd_addr = byte_idx[MEM_AW-1:0];
    assign word        = mem_rd_data;

    always_ff @(posedge CMD_CLK_IN) begin
        bit_sel <= cnt[2:0];
    end

    always_ff @(posedge CMD_CLK_IN) begin
        if (RST_CMD_CLK) begin
            bit_valid   <= 1'b0;
            word_load   <= 1'b0;
            pulse_s1    <= 1'b0;
            start_pulse <= 1'b0;
            ready       <= 1'b1;
            start_ack   <= 1'b0;
        end else begin
            bit_valid <= (state == cmd_seq_pkg::SEND);
            word_load <= (state == cmd_seq_pkg::SEND) && ((cnt[2:0] == 3'd0) || jumped);
            // first pass only so the pulse comes once
            pulse_s1    <= (state == cmd_seq_pkg::SEND) && (cnt == start_repeat)
                           && (rep_cnt == 32'd1);
            start_pulse <= pulse_s1 && !dis_start_pulse;  // aligned with cmd_data
            ready       <= (next_state == cmd_seq_pkg::IDLE);
            if (take && start_req)
                start_ack <= 1'b1;
            else if (!start_req)
                start_ack <= 1'b0;
        end
    end

    a_cnt_bound: assert property (@(posedge CMD_CLK_IN) disable iff (RST_CMD_CLK)
        (state == cmd_seq_pkg::SEND) |-> (cnt <= cmd_size));

    // ack comes up on the first SEND cycle of a request
    a_ack_on_req: assert property (@(posedge CMD_CLK_IN) disable iff (RST_CMD_CLK)
        $rose(start_ack) |-> ($past(start_req) && (state == cmd_seq_pkg::SEND)));

endmodule

// File: rtl/cmd_seq_encoder.sv
// command stream encoder
// serializes the current byte MSB first, masks lanes and drives
// each lane through a dual-edge output stage with clock forwarding

`timescale 1ns/1ps

module cmd_seq_encoder #(
    parameter int OUTPUTS = 1
) (
    input  logic                   CMD_CLK_IN,
    input  logic                   RST_CMD_CLK,
    input  logic [7:0]             word,
    input  logic                   word_load,
    input  logic [2:0]             bit_sel,
    input  logic                   bit_valid,
    input  logic [7:0]             out_en,
    input  cmd_seq_pkg::out_mode_e out_mode,
    input  logic                   dis_clk_fwd,
    output logic [OUTPUTS-1:0]     cmd_data,
    output logic                   cmd_valid,
    output logic [OUTPUTS-1:0]     cmd_clk_out
);

    logic [7:0]         word_q;
    logic [7:0]         cur_word;
    logic               ser;
    logic [7:0]         lane_bits;
    logic [OUTPUTS-1:0] data_pos;   // rising edge register
    logic [OUTPUTS-1:0] data_neg;   // falling edge register
    logic [OUTPUTS-1:0] rise_val;
    logic [OUTPUTS-1:0] fall_val;
    logic               fwd_en;

    always_ff @(posedge CMD_CLK_IN) begin
        if (word_load)
            word_q <= word;
    end

    // bypass on the load cycle
    assign cur_word  = word_load ? word : word_q;
    assign ser       = cur_word[3'd7 - bit_sel] && bit_valid;  // zero between sequences
    assign lane_bits = {8{ser}} & out_en;

    always_ff @(posedge CMD_CLK_IN) begin
        if (RST_CMD_CLK) begin
            data_pos  <= '0;
            cmd_valid <= 1'b0;
            fwd_en    <= 1'b1;
        end else begin
            data_pos  <= lane_bits[OUTPUTS-1:0];
            cmd_valid <= bit_valid;
            fwd_en    <= !dis_clk_fwd;
        end
    end

    // half a cycle behind data_pos
    always_ff @(negedge CMD_CLK_IN) begin
        if (RST_CMD_CLK)
            data_neg <= '0;
        else
            data_neg <= data_pos;
    end

    // first half of the cycle drives rise_val, second half fall_val
    always_comb begin
        case (out_mode)
            cmd_seq_pkg::MODE_POS: begin
                rise_val = data_pos;
                fall_val = data_neg;
            end
            cmd_seq_pkg::MODE_NEG: begin
                rise_val = data_neg;  // still the previous bit
                fall_val = data_neg;
            end
            cmd_seq_pkg::MODE_MANCH_IEEE: begin
                rise_val = ~data_pos;
                fall_val = data_neg;
            end
            default: begin
                rise_val = data_pos;
                fall_val = ~data_neg;
            end
        endcase
    end

    assign cmd_data    = CMD_CLK_IN ? rise_val : fall_val;
    assign cmd_clk_out = {OUTPUTS{CMD_CLK_IN && fwd_en}};  // low when forwarding is off

endmodule

// File: rtl/cmd_seq_mem.sv
// command pattern memory
// bus port writes and reads bytes, sequencer port has a registered read

`timescale 1ns/1ps

module cmd_seq_mem #(
    parameter int ABUSWIDTH    = 16,
    parameter int CMD_MEM_SIZE = 2048
) (
    input  logic                            CMD_CLK_IN,
    input  logic                            mem_wr,
    input  logic [ABUSWIDTH-1:0]            bus_add,
    input  logic [7:0]                      bus_data_in,
    input  logic                            bus_rd,
    input  logic [$clog2(CMD_MEM_SIZE)-1:0] mem_rd_addr,
    output logic [7:0]                      mem_bus_data,
    output logic [7:0]                      mem_rd_data
);

    localparam int MEM_AW = $clog2(CMD_MEM_SIZE);

    logic [7:0]           mem [CMD_MEM_SIZE];
    logic [ABUSWIDTH-1:0] bus_off;

    assign bus_off = bus_add - ABUSWIDTH'(cmd_seq_pkg::ADDR_MEM_BASE);

    always_ff @(posedge CMD_CLK_IN) begin
        if (mem_wr)
            mem[bus_off[MEM_AW-1:0]] <= bus_data_in;
        if (bus_rd)
            mem_bus_data <= mem[bus_off[MEM_AW-1:0]];  // held until next read
        mem_rd_data <= mem[mem_rd_addr];
    end

endmodule

// File: rtl/cmd_seq_pkg.sv
// command sequencer shared definitions
// register map, configuration fields, reset values and enums

package cmd_seq_pkg;

    localparam logic [7:0] VERSION = 8'h01;

    // byte addresses of the register map
    localparam int ADDR_VERSION   = 0;
    localparam int ADDR_START     = 1;  // write starts, read gives finish flag
    localparam int ADDR_CONF      = 2;
    localparam int ADDR_SIZE      = 3;  // 2 bytes little endian
    localparam int ADDR_REPEAT    = 5;  // 4 bytes
    localparam int ADDR_START_REP = 9;  // 2 bytes
    localparam int ADDR_STOP_REP  = 11; // 2 bytes
    localparam int ADDR_OUT_EN    = 13;
    localparam int ADDR_MEM_BASE  = 16;

    // bits of the configuration byte
    localparam int CONF_EXT_START   = 0;
    localparam int CONF_MODE_LSB    = 1;
    localparam int CONF_MODE_MSB    = 2;
    localparam int CONF_DIS_CLK_FWD = 3;
    localparam int CONF_DIS_PULSE   = 4;

    localparam logic [31:0] REPEAT_RESET = 32'd1;
    localparam logic [7:0]  OUT_EN_RESET = 8'hff;

    typedef enum logic [1:0] {
        IDLE     = 2'd0,
        SEND     = 2'd1,
        HOLD_ACK = 2'd2  // drain the output pipe, finish the handshake
    } seq_state_e;

    typedef enum logic [1:0] {
        MODE_POS          = 2'd0,
        MODE_NEG          = 2'd1,
        MODE_MANCH_IEEE   = 2'd2,  // low to high is a one
        MODE_MANCH_THOMAS = 2'd3   // high to low is a one
    } out_mode_e;

endpackage

// File: rtl/cmd_seq_regs.sv
// command sequencer register file
// holds the configuration bytes, decodes bus writes into start and
// memory strobes, and returns read data one cycle after bus_rd

`timescale 1ns/1ps

module cmd_seq_regs #(
    parameter int ABUSWIDTH    = 16,
    parameter int CMD_MEM_SIZE = 2048
) (
    input  logic                      CMD_CLK_IN,
    input  logic                      RST_CMD_CLK,
    input  logic [ABUSWIDTH-1:0]      bus_add,
    input  logic [7:0]                bus_data_in,
    input  logic                      bus_wr,
    input  logic                      bus_rd,
    output logic [7:0]                bus_data_out,
    input  logic [7:0]                mem_bus_data,
    input  logic                      ready,
    output logic                      bus_start,
    output logic                      mem_wr,
    output logic [15:0]               cmd_size,
    output logic [31:0]               repeat_count,
    output logic [15:0]               start_repeat,
    output logic [15:0]               stop_repeat,
    output logic [7:0]                out_en,
    output logic                      ext_start_en,
    output cmd_seq_pkg::out_mode_e    out_mode,
    output logic                      dis_clk_fwd,
    output logic                      dis_start_pulse
);

    logic [7:0] regs_q [16];
    logic       finish;
    logic       ready_q;     // for the rising edge of ready
    logic [7:0] rd_byte_q;
    logic       rd_mem_q;    // last read hit the memory

    assign bus_start = bus_wr && (bus_add == cmd_seq_pkg::ADDR_START);
    assign mem_wr    = bus_wr && (bus_add >= cmd_seq_pkg::ADDR_MEM_BASE)
                       && (bus_add < CMD_MEM_SIZE);

    always_ff @(posedge CMD_CLK_IN) begin
        if (RST_CMD_CLK) begin
            for (int i = 0; i < 16; i++) begin
                regs_q[i] <= 8'd0;
            end
            for (int k = 0; k < 4; k++) begin
                regs_q[cmd_seq_pkg::ADDR_REPEAT + k] <= cmd_seq_pkg::REPEAT_RESET[8*k +: 8];
            end
            regs_q[cmd_seq_pkg::ADDR_OUT_EN] <= cmd_seq_pkg::OUT_EN_RESET;
        end else if (bus_wr && (bus_add >= cmd_seq_pkg::ADDR_CONF)
                     && (bus_add < cmd_seq_pkg::ADDR_MEM_BASE)) begin
            regs_q[bus_add[3:0]] <= bus_data_in;
        end
    end

    // little endian multi-byte fields
    assign cmd_size     = {regs_q[cmd_seq_pkg::ADDR_SIZE + 1], regs_q[cmd_seq_pkg::ADDR_SIZE]};
    assign repeat_count = {regs_q[cmd_seq_pkg::ADDR_REPEAT + 3], regs_q[cmd_seq_pkg::ADDR_REPEAT + 2],
                           regs_q[cmd_seq_pkg::ADDR_REPEAT + 1], regs_q[cmd_seq_pkg::ADDR_REPEAT]};
    assign start_repeat = {regs_q[cmd_seq_pkg::ADDR_START_REP + 1],
                           regs_q[cmd_seq_pkg::ADDR_START_REP]};
    assign stop_repeat  = {regs_q[cmd_seq_pkg::ADDR_STOP_REP + 1],
                           regs_q[cmd_seq_pkg::ADDR_STOP_REP]};
    assign out_en       = regs_q[cmd_seq_pkg::ADDR_OUT_EN];

    assign ext_start_en    = regs_q[cmd_seq_pkg::ADDR_CONF][cmd_seq_pkg::CONF_EXT_START];
    assign dis_clk_fwd     = regs_q[cmd_seq_pkg::ADDR_CONF][cmd_seq_pkg::CONF_DIS_CLK_FWD];
    assign dis_start_pulse = regs_q[cmd_seq_pkg::ADDR_CONF][cmd_seq_pkg::CONF_DIS_PULSE];
    assign out_mode = cmd_seq_pkg::out_mode_e'(
        regs_q[cmd_seq_pkg::ADDR_CONF][cmd_seq_pkg::CONF_MODE_MSB:cmd_seq_pkg::CONF_MODE_LSB]);

    // finish flag, low while a bus-started sequence runs
    always_ff @(posedge CMD_CLK_IN) begin
        if (RST_CMD_CLK) begin
            finish  <= 1'b1;
            ready_q <= 1'b1;
        end else begin
            ready_q <= ready;
            if (bus_start)
                finish <= 1'b0;
            else if (ready && !ready_q)
                finish <= 1'b1;
        end
    end

    always_ff @(posedge CMD_CLK_IN) begin
        if (RST_CMD_CLK) begin
            rd_byte_q <= 8'd0;
            rd_mem_q  <= 1'b0;
        end else if (bus_rd) begin
            rd_mem_q <= (bus_add >= cmd_seq_pkg::ADDR_MEM_BASE) && (bus_add < CMD_MEM_SIZE);
            if (bus_add == cmd_seq_pkg::ADDR_VERSION)
                rd_byte_q <= cmd_seq_pkg::VERSION;
            else if (bus_add == cmd_seq_pkg::ADDR_START)
                rd_byte_q <= {7'd0, finish};
            else if (bus_add < cmd_seq_pkg::ADDR_MEM_BASE)
                rd_byte_q <= regs_q[bus_add[3:0]];
            else
                rd_byte_q <= 8'd0;  // memory or out of range
        end
    end

    // memory data is registered in cmd_seq_mem on the same bus_rd
    assign bus_data_out = rd_mem_q ? mem_bus_data : rd_byte_q;

    a_no_wr_rd: assert property (@(posedge CMD_CLK_IN) disable iff (RST_CMD_CLK)
        !(bus_wr && bus_rd));

endmodule

// File: rtl/cmd_seq_top.sv
// command sequencer top level
// register file, pattern memory, sequencer control and output encoder

`timescale 1ns/1ps

module cmd_seq_top #(
    parameter int ABUSWIDTH    = 16,
    parameter int OUTPUTS      = 1,
    parameter int CMD_MEM_SIZE = 2048
) (
    input  logic                 CMD_CLK_IN,
    input  logic                 RST_CMD_CLK,
    input  logic [ABUSWIDTH-1:0] bus_add,
    input  logic [7:0]           bus_data_in,
    input  logic                 bus_wr,
    input  logic                 bus_rd,
    output logic [7:0]           bus_data_out,
    input  logic                 ext_start_flag,
    input  logic                 start_req,
    output logic                 start_ack,
    output logic [OUTPUTS-1:0]   cmd_data,
    output logic [OUTPUTS-1:0]   cmd_clk_out,
    output logic                 cmd_valid,
    output logic                 ready,
    output logic                 start_pulse
);

    logic [7:0]                      mem_bus_data;
    logic [7:0]                      mem_rd_data;
    logic [$clog2(CMD_MEM_SIZE)-1:0] mem_rd_addr;
    logic                            mem_wr;
    logic                            bus_start;
    logic [15:0]                     cmd_size;
    logic [31:0]                     repeat_count;
    logic [15:0]                     start_repeat;
    logic [15:0]                     stop_repeat;
    logic [7:0]                      out_en;
    logic                            ext_start_en;
    cmd_seq_pkg::out_mode_e          out_mode;
    logic                            dis_clk_fwd;
    logic                            dis_start_pulse;
    logic [7:0]                      word;
    logic                            word_load;
    logic [2:0]                      bit_sel;
    logic                            bit_valid;

    cmd_seq_regs #(.ABUSWIDTH(ABUSWIDTH), .CMD_MEM_SIZE(CMD_MEM_SIZE)) u_regs (
        .CMD_CLK_IN, .RST_CMD_CLK, .bus_add, .bus_data_in, .bus_wr, .bus_rd,
        .bus_data_out, .mem_bus_data, .ready, .bus_start, .mem_wr,
        .cmd_size, .repeat_count, .start_repeat, .stop_repeat, .out_en,
        .ext_start_en, .out_mode, .dis_clk_fwd, .dis_start_pulse
    );

    cmd_seq_mem #(.ABUSWIDTH(ABUSWIDTH), .CMD_MEM_SIZE(CMD_MEM_SIZE)) u_mem (
        .CMD_CLK_IN, .mem_wr, .bus_add, .bus_data_in, .bus_rd,
        .mem_rd_addr, .mem_bus_data, .mem_rd_data
    );

    cmd_seq_ctrl #(.CMD_MEM_SIZE(CMD_MEM_SIZE)) u_ctrl (
        .CMD_CLK_IN, .RST_CMD_CLK, .bus_start, .ext_start_flag, .ext_start_en,
        .start_req, .start_ack, .cmd_size, .repeat_count, .start_repeat,
        .stop_repeat, .dis_start_pulse, .ready, .start_pulse, .mem_rd_addr,
        .mem_rd_data, .word, .word_load, .bit_sel, .bit_valid
    );

    cmd_seq_encoder #(.OUTPUTS(OUTPUTS)) u_encoder (
        .CMD_CLK_IN, .RST_CMD_CLK, .word, .word_load, .bit_sel, .bit_valid,
        .out_en, .out_mode, .dis_clk_fwd, .cmd_data, .cmd_valid, .cmd_clk_out
    );

endmodule

// File: testbench/tb_cmd_seq.sv
// command sequencer testbench
// loads pattern and configuration over the bus, starts each table row
// from its source and checks the captured lanes against the stream rule

`timescale 1ns/1ps

module tb_cmd_seq;

    localparam int LANES = 4;
    localparam int NROWS = 6;

    logic             CMD_CLK_IN;
    logic             RST_CMD_CLK;
    logic [15:0]      bus_add;
    logic [7:0]       bus_data_in;
    logic             bus_wr;
    logic             bus_rd;
    logic [7:0]       bus_data_out;
    logic             ext_start_flag;
    logic             start_req;
    logic             start_ack;
    logic [LANES-1:0] cmd_data;
    logic [LANES-1:0] cmd_clk_out;
    logic             cmd_valid;
    logic             ready;
    logic             start_pulse;

    // size, repeat, start-repeat, stop-repeat, mode, lane enable,
    // source (0 bus, 1 ext flag, 2 handshake), pulses, clock fwd off
    int         t_size   [NROWS] = '{16, 37, 29, 24, 20, 45};
    int         t_rep    [NROWS] = '{1, 3, 5, 2, 3, 1};
    int         t_a      [NROWS] = '{0, 5, 3, 8, 0, 2};
    int         t_b      [NROWS] = '{0, 6, 4, 8, 0, 2};
    int         t_mode   [NROWS] = '{0, 0, 1, 2, 3, 3};
    logic [7:0] t_en     [NROWS] = '{8'h0f, 8'h05, 8'h0f, 8'h03, 8'h0a, 8'h0f};
    int         t_src    [NROWS] = '{0, 0, 1, 2, 0, 2};
    int         t_pulses [NROWS] = '{1, 1, 0, 1, 1, 0};
    int         t_nofwd  [NROWS] = '{0, 0, 0, 1, 0, 0};

    logic [7:0]       pat [64];
    logic             exp_bits [$];
    logic [LANES-1:0] cap_hi [$];   // quarter cycle samples
    logic [LANES-1:0] cap_lo [$];   // three quarter samples
    int               pulse_at [$];
    int               errors;
    int               checks;
    int               tests;
    logic             clk_bad;

    cmd_seq_top #(.ABUSWIDTH(16), .OUTPUTS(LANES), .CMD_MEM_SIZE(2048)) u_dut (
        .CMD_CLK_IN, .RST_CMD_CLK, .bus_add, .bus_data_in, .bus_wr, .bus_rd,
        .bus_data_out, .ext_start_flag, .start_req, .start_ack, .cmd_data,
        .cmd_clk_out, .cmd_valid, .ready, .start_pulse
    );

    initial CMD_CLK_IN = 1'b0;
    always #20 CMD_CLK_IN = ~CMD_CLK_IN;

    // bus tasks start and end on a falling edge
    task automatic bus_write(input int addr, input logic [7:0] data);
        bus_add     = 16'(addr);
        bus_data_in = data;
        bus_wr      = 1'b1;
        @(negedge CMD_CLK_IN);
        bus_wr      = 1'b0;
    endtask

    task automatic bus_read(input int addr, output logic [7:0] data);
        bus_add = 16'(addr);
        bus_rd  = 1'b1;
        @(negedge CMD_CLK_IN);
        bus_rd  = 1'b0;
        data    = bus_data_out;  // valid one cycle after bus_rd
    endtask

    task automatic expect_read(input int addr, input logic [7:0] exp, input string name);
        logic [7:0] got;
        bus_read(addr, got);
        checks++;
        if (got !== exp) begin
            $display("ERROR %s exp %h got %h", name, exp, got);
            errors++;
        end
    endtask

    task automatic write_field(input int addr, input int nbytes, input int value);
        for (int k = 0; k < nbytes; k++) begin
            bus_write(addr + k, 8'(value >> (8 * k)));  // little endian
        end
    endtask

    function automatic logic pattern_bit(input int i);
        return pat[i / 8][7 - (i % 8)];
    endfunction

    // head once, middle R-1 more times, then tail
    function automatic void build_stream(input int r);
        int s;
        int a;
        int b;
        s = t_size[r];
        a = t_a[r];
        b = t_b[r];
        exp_bits.delete();
        for (int i = 0; i < s - b; i++) begin
            exp_bits.push_back(pattern_bit(i));
        end
        for (int p = 1; p < t_rep[r]; p++) begin
            for (int i = a; i < s - b; i++) begin
                exp_bits.push_back(pattern_bit(i));
            end
        end
        for (int i = s - b; i < s; i++) begin
            exp_bits.push_back(pattern_bit(i));
        end
    endfunction

    task automatic capture_stream(input int nofwd);
        int               n;
        int               waited;
        logic [LANES-1:0] fwd_exp;
        cap_hi.delete();
        cap_lo.delete();
        pulse_at.delete();
        n       = 0;
        waited  = 0;
        fwd_exp = nofwd ? '0 : '1;
        @(posedge CMD_CLK_IN);
        #10;
        while (!cmd_valid && waited < 20) begin
            @(posedge CMD_CLK_IN);
            #10;
            waited++;
        end
        if (!cmd_valid) begin
            $display("cmd_valid did not rise within 20 cycles of the start");
            errors++;
            return;
        end
        while (cmd_valid) begin
            cap_hi.push_back(cmd_data);
            if (start_pulse)
                pulse_at.push_back(n);
            if (cmd_clk_out !== fwd_exp)
                clk_bad = 1'b1;
            #20;
            cap_lo.push_back(cmd_data);
            if (cmd_clk_out !== '0)
                clk_bad = 1'b1;
            @(posedge CMD_CLK_IN);
            #10;
            n++;
        end
    endtask

    task automatic apply_start(input int src);
        int waited;
        waited = 0;
        if (src == 0) begin
            bus_write(cmd_seq_pkg::ADDR_START, 8'h00);
            expect_read(cmd_seq_pkg::ADDR_START, 8'h00, "finish flag");
        end else if (src == 1) begin
            ext_start_flag = 1'b1;
            @(negedge CMD_CLK_IN);
            ext_start_flag = 1'b0;
        end else begin
            checks++;
            if (start_ack !== 1'b0) begin
                $display("ERROR start_ack exp %h got %h", 1'b0, start_ack);
                errors++;
            end
            start_req = 1'b1;
            while (!start_ack && waited < 10) begin
                @(negedge CMD_CLK_IN);
                waited++;
            end
            checks++;
            if (!start_ack) begin
                $display("start_ack did not rise after start_req");
                errors++;
            end
            start_req = 1'b0;
            @(negedge CMD_CLK_IN);
            checks++;
            if (start_ack !== 1'b0) begin
                $display("ERROR start_ack exp %h got %h", 1'b0, start_ack);
                errors++;
            end
            bus_write(cmd_seq_pkg::ADDR_START, 8'h00);  // second start while sending
        end
    endtask

    task automatic compare_stream(input int r);
        logic [LANES-1:0] v;
        logic [LANES-1:0] vp;
        logic [LANES-1:0] eh;
        logic [LANES-1:0] el;
        checks++;
        if (cap_hi.size() != exp_bits.size()) begin
            $display("ERROR cmd_valid length exp %h got %h", exp_bits.size(), cap_hi.size());
            errors++;
        end else begin
            for (int k = 0; k < exp_bits.size(); k++) begin
                v  = {LANES{exp_bits[k]}} & t_en[r][LANES-1:0];
                vp = (k == 0) ? '0 : {LANES{exp_bits[k - 1]}} & t_en[r][LANES-1:0];
                case (t_mode[r])
                    0: begin eh = v;  el = v;  end
                    1: begin eh = vp; el = v;  end  // half a cycle late
                    2: begin eh = ~v; el = v;  end
                    default: begin eh = v; el = ~v; end
                endcase
                if (cap_hi[k] !== eh || cap_lo[k] !== el) begin
                    $display("ERROR cmd_data bit %0d exp %h/%h got %h/%h",
                             k, eh, el, cap_hi[k], cap_lo[k]);
                    errors++;
                    break;
                end
            end
        end
        checks++;
        if (pulse_at.size() != t_pulses[r]) begin
            $display("ERROR start_pulse count exp %h got %h", t_pulses[r], pulse_at.size());
            errors++;
        end else if (t_pulses[r] == 1 && pulse_at[0] != t_a[r]) begin
            $display("ERROR start_pulse position exp %h got %h", t_a[r], pulse_at[0]);
            errors++;
        end
        checks++;
        if (clk_bad) begin
            $display("cmd_clk_out did not match the clock forwarding setting");
            errors++;
        end
    endtask

    task automatic run_row(input int r);
        int conf;
        int nbytes;
        int err0;
        int waited;
        err0   = errors;
        waited = 0;
        conf   = (t_mode[r] << cmd_seq_pkg::CONF_MODE_LSB)
                 | (t_nofwd[r] << cmd_seq_pkg::CONF_DIS_CLK_FWD)
                 | ((t_pulses[r] == 0 ? 1 : 0) << cmd_seq_pkg::CONF_DIS_PULSE);
        write_field(cmd_seq_pkg::ADDR_SIZE, 2, t_size[r]);
        write_field(cmd_seq_pkg::ADDR_REPEAT, 4, t_rep[r]);
        write_field(cmd_seq_pkg::ADDR_START_REP, 2, t_a[r]);
        write_field(cmd_seq_pkg::ADDR_STOP_REP, 2, t_b[r]);
        bus_write(cmd_seq_pkg::ADDR_OUT_EN, t_en[r]);
        bus_write(cmd_seq_pkg::ADDR_CONF, 8'(conf));
        nbytes = (t_size[r] + 7) / 8;
        for (int j = 0; j < nbytes; j++) begin
            pat[j] = 8'($urandom);
            bus_write(cmd_seq_pkg::ADDR_MEM_BASE + j, pat[j]);
        end
        build_stream(r);
        if (t_src[r] == 1) begin
            // flag must do nothing while its enable is clear
            ext_start_flag = 1'b1;
            @(negedge CMD_CLK_IN);
            ext_start_flag = 1'b0;
            repeat (6) @(negedge CMD_CLK_IN);
            checks++;
            if (cmd_valid !== 1'b0 || ready !== 1'b1) begin
                $display("ext_start_flag started a sequence while disabled");
                errors++;
            end
            bus_write(cmd_seq_pkg::ADDR_CONF, 8'(conf | (1 << cmd_seq_pkg::CONF_EXT_START)));
        end
        clk_bad = 1'b0;
        fork
            capture_stream(t_nofwd[r]);
            apply_start(t_src[r]);
        join
        compare_stream(r);
        @(negedge CMD_CLK_IN);
        while (!ready && waited < 10) begin
            @(negedge CMD_CLK_IN);
            waited++;
        end
        checks++;
        if (!ready) begin
            $display("ready did not return after the stream");
            errors++;
        end
        @(negedge CMD_CLK_IN);
        expect_read(cmd_seq_pkg::ADDR_START, 8'h01, "finish flag");
        repeat (6) @(negedge CMD_CLK_IN);
        checks++;
        if (cmd_valid !== 1'b0 || start_ack !== 1'b0) begin
            $display("a second sequence followed the first one");
            errors++;
        end
        tests++;
        $display("test %0d size %0d repeat %0d mode %0d source %0d: %0d bits, %0d errors",
                 r, t_size[r], t_rep[r], t_mode[r], t_src[r], exp_bits.size(), errors - err0);
    endtask

    initial begin : main
        logic [7:0] mem_ref [8];
        logic [7:0] exp;
        bus_add        = '0;
        bus_data_in    = '0;
        bus_wr         = 1'b0;
        bus_rd         = 1'b0;
        ext_start_flag = 1'b0;
        start_req      = 1'b0;
        RST_CMD_CLK    = 1'b1;
        errors         = 0;
        checks         = 0;
        tests          = 0;
        void'($urandom(32'hc1ab2d8c));
        repeat (5) @(posedge CMD_CLK_IN);
        @(negedge CMD_CLK_IN);
        RST_CMD_CLK = 1'b0;
        @(negedge CMD_CLK_IN);

        // reset state and register map
        checks++;
        if (ready !== 1'b1 || start_ack !== 1'b0 || start_pulse !== 1'b0
            || cmd_valid !== 1'b0 || cmd_data !== '0) begin
            $display("outputs are not at their reset values");
            errors++;
        end
        expect_read(cmd_seq_pkg::ADDR_VERSION, cmd_seq_pkg::VERSION, "version");
        expect_read(cmd_seq_pkg::ADDR_START, 8'h01, "finish flag");
        for (int a = 2; a < 16; a++) begin
            exp = (a == 5) ? 8'h01 : ((a == 13) ? 8'hff : 8'h00);
            expect_read(a, exp, $sformatf("register %0d", a));
        end
        for (int j = 0; j < 8; j++) begin
            mem_ref[j] = 8'($urandom);
            bus_write(cmd_seq_pkg::ADDR_MEM_BASE + j, mem_ref[j]);
        end
        for (int j = 0; j < 8; j++) begin
            expect_read(cmd_seq_pkg::ADDR_MEM_BASE + j, mem_ref[j], "memory byte");
        end
        expect_read(2100, 8'h00, "out of range read");
        tests++;
        $display("test reset: registers and memory readback, %0d errors", errors);

        for (int r = 0; r < NROWS; r++) begin
            run_row(r);
        end

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

    initial begin : watchdog
        int limit;
        limit = 200;  // reset and register checks
        for (int r = 0; r < NROWS; r++) begin
            limit += t_size[r] * t_rep[r] + 50;
        end
        repeat (limit) @(posedge CMD_CLK_IN);
        $display("watchdog expired after %0d cycles", limit);
        $display("Checks failed");
        $finish;
    end

endmodule
